//--- huffman_pkg.sv
`default_nettype none

package huffman_pkg;

    // table and codebook sizes
    localparam int max_records = 16;  // merge records held in the table
    localparam int rec_idx_w = 4;     // bits of a record index
    localparam int max_path = 128;    // code path bits per character
    localparam int max_chars = 256;   // codebook entries, one per character

    // tree node as stored in a merge record
    typedef struct packed {
        logic       is_sum;  // 1 = sum node, idx names the record
        logic [7:0] idx;     // record index or character index
    } node_t;

    // one merge step of the tree build
    typedef struct packed {
        node_t least1;  // least frequent node, branch bit 0
        node_t least2;  // second least frequent node, branch bit 1
    } merge_rec_t;

    // path is right aligned, first branch in the highest used bit
    typedef struct packed {
        logic [7:0]          len;
        logic [max_path-1:0] path;
    } cb_entry_t;

    typedef logic [7:0] byte_t;

    // header serializer states
    typedef enum logic [1:0] {
        hdr_idle,
        hdr_shift,
        hdr_done
    } hdr_state_e;

    // tree walk states
    typedef enum logic [2:0] {
        walk_idle,
        walk_fetch,
        walk_emit,
        walk_wait,
        walk_end
    } walk_state_e;

endpackage

`default_nettype wire

//--- merge_table.sv
`default_nettype none

module merge_table (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load_en,
    input  logic [huffman_pkg::rec_idx_w-1:0]   load_addr,
    input  huffman_pkg::merge_rec_t             load_rec,
    input  logic [huffman_pkg::rec_idx_w-1:0]   rd_addr,
    output huffman_pkg::merge_rec_t             rd_rec
);

    huffman_pkg::merge_rec_t recs [huffman_pkg::max_records];

    // one record per cycle from the load port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < huffman_pkg::max_records; i++) begin
                recs[i] <= '0;
            end
        end else if (load_en) begin
            recs[load_addr] <= load_rec;
        end
    end

    // walk reads the record it points at in the same cycle
    assign rd_rec = recs[rd_addr];

endmodule

`default_nettype wire

//--- cb_synthesis.sv
`default_nettype none

module cb_synthesis (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic [huffman_pkg::rec_idx_w:0]     num_records,
    output logic [huffman_pkg::rec_idx_w-1:0]   rd_addr,
    input  huffman_pkg::merge_rec_t             rd_rec,
    output logic                                char_found,
    output logic [7:0]                          char_index,
    output huffman_pkg::node_t                  least1,
    output huffman_pkg::node_t                  least2,
    input  logic                                write_finish,
    output logic                                cb_wr_en,
    output logic [7:0]                          cb_wr_addr,
    output huffman_pkg::cb_entry_t              cb_wr_entry,
    output logic                                flush
);

    huffman_pkg::walk_state_e state;

    // explicit stack of frames, top is the record being visited
    logic [huffman_pkg::rec_idx_w-1:0] stk_rec   [huffman_pkg::max_records];
    logic [huffman_pkg::max_path-1:0]  stk_path  [huffman_pkg::max_records];
    logic [7:0]                        stk_len   [huffman_pkg::max_records];
    logic                              stk_child [huffman_pkg::max_records];

    logic [huffman_pkg::rec_idx_w-1:0] top;
    logic [huffman_pkg::rec_idx_w-1:0] frame_idx;
    logic [huffman_pkg::rec_idx_w:0]   last_rec;
    logic                              cur_child;
    huffman_pkg::node_t                cur_node;
    logic [huffman_pkg::max_path-1:0]  child_path;
    logic [7:0]                        child_len;

    assign last_rec  = num_records - 1'b1;     // root is the last record
    assign rd_addr   = stk_rec[top];
    assign cur_child = stk_child[top];         // 0 = least1 next, 1 = least2 next
    assign cur_node  = cur_child ? rd_rec.least2 : rd_rec.least1;

    assign child_path = {stk_path[top][huffman_pkg::max_path-2:0], cur_child};
    assign child_len  = stk_len[top] + 8'd1;

    // least2 sum replaces its parent frame, parent has nothing left to visit
    assign frame_idx = cur_child ? top : top + 1'b1;

    assign char_found        = (state == huffman_pkg::walk_emit);
    assign char_index        = cur_node.idx;
    assign least1            = rd_rec.least1;
    assign least2            = rd_rec.least2;
    assign cb_wr_en          = char_found;
    assign cb_wr_addr        = cur_node.idx;
    assign cb_wr_entry.len   = child_len;
    assign cb_wr_entry.path  = child_path;
    assign flush             = (state == huffman_pkg::walk_end);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= huffman_pkg::walk_idle;
            top   <= '0;
        end else begin
            case (state)
                huffman_pkg::walk_idle: begin
                    if (start) begin
                        top   <= '0;
                        state <= (num_records == '0) ? huffman_pkg::walk_end
                                                     : huffman_pkg::walk_fetch;
                    end
                end
                huffman_pkg::walk_fetch: begin
                    if (cur_node.is_sum) begin
                        top <= frame_idx;              // descend, one record per cycle
                    end else begin
                        state <= huffman_pkg::walk_emit;
                    end
                end
                huffman_pkg::walk_emit: begin
                    state <= huffman_pkg::walk_wait;
                end
                huffman_pkg::walk_wait: begin
                    if (write_finish) begin
                        if (!cur_child) begin
                            state <= huffman_pkg::walk_fetch;
                        end else if (top == '0) begin
                            state <= huffman_pkg::walk_end;  // root frame finished
                        end else begin
                            top   <= top - 1'b1;             // back to the parent's least2
                            state <= huffman_pkg::walk_fetch;
                        end
                    end
                end
                huffman_pkg::walk_end: begin
                    state <= huffman_pkg::walk_idle;
                end
                default: state <= huffman_pkg::walk_idle;
            endcase
        end
    end

    // stack contents
    always_ff @(posedge clk) begin
        if (state == huffman_pkg::walk_idle && start) begin
            stk_rec[0]   <= last_rec[huffman_pkg::rec_idx_w-1:0];
            stk_path[0]  <= '0;
            stk_len[0]   <= '0;
            stk_child[0] <= 1'b0;
        end
        if (state == huffman_pkg::walk_fetch && cur_node.is_sum) begin
            stk_child[top]       <= 1'b1;  // parent goes on with least2 later
            stk_rec[frame_idx]   <= cur_node.idx[huffman_pkg::rec_idx_w-1:0];
            stk_path[frame_idx]  <= child_path;
            stk_len[frame_idx]   <= child_len;
            stk_child[frame_idx] <= 1'b0;
        end
        if (state == huffman_pkg::walk_wait && write_finish && !cur_child) begin
            stk_child[top] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- header_synthesis.sv
`default_nettype none

module header_synthesis (
    input  logic               clk,
    input  logic               rst,
    input  logic               char_found,
    input  logic [7:0]         char_index,
    input  huffman_pkg::node_t least1,
    input  huffman_pkg::node_t least2,
    output logic               bit_valid,
    output logic               bit1,
    output logic               write_finish
);

    huffman_pkg::hdr_state_e state;

    logic [8:0] shreg;      // leading 1 then index, msb goes out first
    logic [3:0] count;      // bits sent so far
    logic [1:0] zeroes;     // trailing zeroes for the current character
    logic [1:0] zero_cnt;

    // tree shape marker from the record the character came from
    always_comb begin
        if (!least1.is_sum && !least2.is_sum && char_index == least2.idx) begin
            zero_cnt = 2'd2;  // second char of a leaf pair closes the pair
        end else if (least1.is_sum != least2.is_sum) begin
            zero_cnt = 2'd1;
        end else begin
            zero_cnt = 2'd0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= huffman_pkg::hdr_idle;
            count  <= '0;
            zeroes <= '0;
        end else begin
            case (state)
                huffman_pkg::hdr_idle: begin
                    if (char_found) begin
                        state  <= huffman_pkg::hdr_shift;
                        count  <= '0;
                        zeroes <= zero_cnt;
                    end
                end
                huffman_pkg::hdr_shift: begin
                    count <= count + 4'd1;
                    if (count == 4'd8 + {2'b00, zeroes}) begin
                        state <= huffman_pkg::hdr_done;  // last bit on the line now
                    end
                end
                huffman_pkg::hdr_done: begin
                    state <= huffman_pkg::hdr_idle;
                end
                default: state <= huffman_pkg::hdr_idle;
            endcase
        end
    end

    // zeroes shift in behind the index, so the trailing bits come out as 0
    always_ff @(posedge clk) begin
        if (state == huffman_pkg::hdr_idle && char_found) begin
            shreg <= {1'b1, char_index};
        end else if (state == huffman_pkg::hdr_shift) begin
            shreg <= {shreg[7:0], 1'b0};
        end
    end

    assign bit_valid    = (state == huffman_pkg::hdr_shift);
    assign bit1         = bit_valid & shreg[8];
    assign write_finish = (state == huffman_pkg::hdr_done);

endmodule

`default_nettype wire

//--- bit_packer.sv
`default_nettype none

module bit_packer (
    input  logic       clk,
    input  logic       rst,
    input  logic       bit_valid,
    input  logic       bit1,
    input  logic       flush,
    input  logic       start,
    output logic       byte_valid,
    output logic [7:0] byte_out,
    output logic       done
);

    huffman_pkg::byte_t sh;   // newest bit in bit 0
    logic [2:0]         fill; // bits held in sh
    logic               flush_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill       <= '0;
            byte_valid <= 1'b0;
            flush_d    <= 1'b0;
            done       <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            flush_d    <= flush;
            if (bit_valid) begin
                fill <= fill + 3'd1;           // wraps to 0 on the eighth bit
                if (fill == 3'd7) begin
                    byte_valid <= 1'b1;
                end
            end else if (flush) begin
                fill       <= '0;
                byte_valid <= (fill != 3'd0);  // nothing to pad when empty
            end
            if (start) begin
                done <= 1'b0;
            end else if (flush_d) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bit_valid) begin
            sh <= {sh[6:0], bit1};
        end
        if (bit_valid && fill == 3'd7) begin
            byte_out <= {sh[6:0], bit1};
        end else if (flush && fill != 3'd0) begin
            byte_out <= sh << (4'd8 - {1'b0, fill});  // first bit to bit 7, zero pad
        end
    end

endmodule

`default_nettype wire

//--- codebook_ram.sv
`default_nettype none

module codebook_ram (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   wr_en,
    input  logic [7:0]             wr_addr,
    input  huffman_pkg::cb_entry_t wr_entry,
    input  logic [7:0]             rd_addr,
    output huffman_pkg::cb_entry_t rd_entry
);

    huffman_pkg::cb_entry_t mem [huffman_pkg::max_chars];

    logic [huffman_pkg::max_chars-1:0] valid;  // entry written since last start

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (start) begin
            valid <= '0;                  // forget the previous tree
        end else if (wr_en) begin
            valid[wr_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_entry;
        end
    end

    // unused characters read back as length 0
    assign rd_entry = valid[rd_addr] ? mem[rd_addr] : '0;

endmodule

`default_nettype wire

//--- huffman_header_top.sv
`default_nettype none

module huffman_header_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic [huffman_pkg::rec_idx_w:0]     num_records,
    input  logic                                load_en,
    input  logic [huffman_pkg::rec_idx_w-1:0]   load_addr,
    input  huffman_pkg::merge_rec_t             load_rec,
    input  logic [7:0]                          cb_rd_addr,
    output huffman_pkg::cb_entry_t              cb_rd_entry,
    output logic                                byte_valid,
    output logic [7:0]                          byte_out,
    output logic                                done
);

    logic [huffman_pkg::rec_idx_w-1:0] rd_addr;
    huffman_pkg::merge_rec_t           rd_rec;
    logic                              char_found;
    logic [7:0]                        char_index;
    huffman_pkg::node_t                least1;
    huffman_pkg::node_t                least2;
    logic                              write_finish;
    logic                              cb_wr_en;
    logic [7:0]                        cb_wr_addr;
    huffman_pkg::cb_entry_t            cb_wr_entry;
    logic                              flush;
    logic                              bit_valid;
    logic                              bit1;

    merge_table u_table (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_rec  (load_rec),
        .rd_addr   (rd_addr),
        .rd_rec    (rd_rec)
    );

    cb_synthesis u_walk (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .num_records  (num_records),
        .rd_addr      (rd_addr),
        .rd_rec       (rd_rec),
        .char_found   (char_found),
        .char_index   (char_index),
        .least1       (least1),
        .least2       (least2),
        .write_finish (write_finish),
        .cb_wr_en     (cb_wr_en),
        .cb_wr_addr   (cb_wr_addr),
        .cb_wr_entry  (cb_wr_entry),
        .flush        (flush)
    );

    header_synthesis u_header (
        .clk          (clk),
        .rst          (rst),
        .char_found   (char_found),
        .char_index   (char_index),
        .least1       (least1),
        .least2       (least2),
        .bit_valid    (bit_valid),
        .bit1         (bit1),
        .write_finish (write_finish)
    );

    bit_packer u_packer (
        .clk        (clk),
        .rst        (rst),
        .bit_valid  (bit_valid),
        .bit1       (bit1),
        .flush      (flush),
        .start      (start),
        .byte_valid (byte_valid),
        .byte_out   (byte_out),
        .done       (done)
    );

    codebook_ram u_codebook (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .wr_en    (cb_wr_en),
        .wr_addr  (cb_wr_addr),
        .wr_entry (cb_wr_entry),
        .rd_addr  (cb_rd_addr),
        .rd_entry (cb_rd_entry)
    );

endmodule

`default_nettype wire

//--- tb_huffman_ref.svh
`ifndef TB_HUFFMAN_REF_SVH
`define TB_HUFFMAN_REF_SVH

huffman_pkg::merge_rec_t tbl [huffman_pkg::max_records];  // table under test
int                      tbl_n;
logic [7:0]              exp_bytes [$];
huffman_pkg::cb_entry_t  exp_cb [huffman_pkg::max_chars];
logic                    hdr_bits [$];

// nodes still to visit, kept as parallel stacks
huffman_pkg::node_t               pend_node [$];
int                               pend_parent [$];
logic [huffman_pkg::max_path-1:0] pend_path [$];
logic [7:0]                       pend_len [$];

function automatic void push_children(input int r, input logic [huffman_pkg::max_path-1:0] path,
                                      input logic [7:0] len);
    // least2 goes on first so least1 comes off first
    pend_node.push_back(tbl[r].least2);
    pend_parent.push_back(r);
    pend_path.push_back({path[huffman_pkg::max_path-2:0], 1'b1});
    pend_len.push_back(len + 8'd1);
    pend_node.push_back(tbl[r].least1);
    pend_parent.push_back(r);
    pend_path.push_back({path[huffman_pkg::max_path-2:0], 1'b0});
    pend_len.push_back(len + 8'd1);
endfunction

// depth first from the root, fills hdr_bits and exp_cb
function automatic void walk_tree();
    huffman_pkg::node_t               nd;
    huffman_pkg::merge_rec_t          pr;
    logic [huffman_pkg::max_path-1:0] path;
    logic [7:0]                       len;
    int                               zeroes;
    int                               i;
    hdr_bits.delete();
    for (i = 0; i < huffman_pkg::max_chars; i++) begin
        exp_cb[i] = '0;
    end
    push_children(tbl_n - 1, '0, 8'd0);
    while (pend_node.size() > 0) begin
        nd   = pend_node.pop_back();
        pr   = tbl[pend_parent.pop_back()];
        path = pend_path.pop_back();
        len  = pend_len.pop_back();
        if (nd.is_sum) begin
            push_children(nd.idx, path, len);
        end else begin
            exp_cb[nd.idx].len  = len;
            exp_cb[nd.idx].path = path;
            if (!pr.least1.is_sum && !pr.least2.is_sum && path[0]) begin
                zeroes = 2;  // least2 of a character pair
            end else if (pr.least1.is_sum != pr.least2.is_sum) begin
                zeroes = 1;
            end else begin
                zeroes = 0;
            end
            hdr_bits.push_back(1'b1);
            for (i = 7; i >= 0; i--) begin
                hdr_bits.push_back(nd.idx[i]);
            end
            for (i = 0; i < zeroes; i++) begin
                hdr_bits.push_back(1'b0);
            end
        end
    end
endfunction

// header bytes, msb first, tail padded with zeroes; also refreshes exp_cb
function automatic void ref_header_bytes();
    logic [7:0] acc;
    int         fill;
    int         i;
    walk_tree();
    exp_bytes.delete();
    acc  = '0;
    fill = 0;
    for (i = 0; i < hdr_bits.size(); i++) begin
        acc = {acc[6:0], hdr_bits[i]};
        fill++;
        if (fill == 8) begin
            exp_bytes.push_back(acc);
            fill = 0;
        end
    end
    if (fill != 0) begin
        exp_bytes.push_back(acc << (8 - fill));
    end
endfunction

function automatic huffman_pkg::cb_entry_t ref_codebook(input int c);
    return exp_cb[c];
endfunction

`endif

//--- tb_huffman_header.sv
`default_nettype none

module tb_huffman_header;

    localparam int num_random  = 20;
    localparam int num_tests   = num_random + 4;  // two directed, reset, final full table
    localparam int cycle_limit = num_tests * (16 + 16 * 14 + 40);

    logic                              clk;
    logic                              rst;
    logic                              start;
    logic [huffman_pkg::rec_idx_w:0]   num_records;
    logic                              load_en;
    logic [huffman_pkg::rec_idx_w-1:0] load_addr;
    huffman_pkg::merge_rec_t           load_rec;
    logic [7:0]                        cb_rd_addr;
    huffman_pkg::cb_entry_t            cb_rd_entry;
    logic                              byte_valid;
    logic [7:0]                        byte_out;
    logic                              done;

    int   cycles;
    int   rx_count;
    int   byte_errs;
    int   entry_errs;
    int   other_errs;
    int   seed;
    logic used [huffman_pkg::max_chars];       // characters of the current table
    logic prev_used [huffman_pkg::max_chars];  // characters of the table before

    `include "tb_huffman_ref.svh"

    huffman_header_top dut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .num_records (num_records),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_rec    (load_rec),
        .cb_rd_addr  (cb_rd_addr),
        .cb_rd_entry (cb_rd_entry),
        .byte_valid  (byte_valid),
        .byte_out    (byte_out),
        .done        (done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, done never came", cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("ERR %s exp %h got %h", name, exp, act);
            byte_errs++;
        end
    endtask

    task automatic check_entry(input logic [7:0] ch, input huffman_pkg::cb_entry_t exp,
                               input huffman_pkg::cb_entry_t act);
        if (exp !== act) begin
            $display("ERR cb_rd_entry[%h] exp len %h path %h got len %h path %h",
                     ch, exp.len, exp.path, act.len, act.path);
            entry_errs++;
        end
    endtask

    // compare each byte as it leaves the packer
    always @(posedge clk) begin
        if (!rst && byte_valid) begin
            if (rx_count < exp_bytes.size()) begin
                check_byte("byte_out", exp_bytes[rx_count], byte_out);
            end else begin
                $display("extra byte %h on byte_out when no more bytes were expected", byte_out);
                other_errs++;
            end
            rx_count++;
        end
    end

    function automatic huffman_pkg::node_t char_node(input logic [7:0] c);
        return {1'b0, c};
    endfunction

    function automatic huffman_pkg::node_t sum_node(input int r);
        return {1'b1, r[7:0]};
    endfunction

    task automatic new_table();
        int c;
        for (c = 0; c < huffman_pkg::max_chars; c++) begin
            prev_used[c] = used[c];
            used[c]      = 1'b0;
        end
    endtask

    task automatic put_rec(input int r, input huffman_pkg::node_t l1, input huffman_pkg::node_t l2);
        tbl[r] = {l1, l2};
        if (!l1.is_sum) used[l1.idx] = 1'b1;
        if (!l2.is_sum) used[l2.idx] = 1'b1;
    endtask

    // distinct characters merged in random pairs, sums always point back
    task automatic make_random_table(input int n);
        huffman_pkg::node_t pool [$];
        huffman_pkg::node_t a;
        huffman_pkg::node_t b;
        int                 c;
        int                 r;
        int                 i;
        while (pool.size() < n + 1) begin
            c = $urandom % huffman_pkg::max_chars;
            if (!used[c]) begin
                used[c] = 1'b1;
                pool.push_back(char_node(c[7:0]));
            end
        end
        for (r = 0; r < n; r++) begin
            i = $urandom % pool.size();
            a = pool[i];
            pool.delete(i);
            i = $urandom % pool.size();
            b = pool[i];
            pool.delete(i);
            put_rec(r, a, b);
            pool.push_back(sum_node(r));
        end
    endtask

    task automatic load_and_start();
        int r;
        for (r = 0; r < tbl_n; r++) begin
            load_en   = 1'b1;
            load_addr = r[huffman_pkg::rec_idx_w-1:0];
            load_rec  = tbl[r];
            @(posedge clk);
            #1;
        end
        load_en     = 1'b0;
        num_records = tbl_n[huffman_pkg::rec_idx_w:0];
        start       = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic check_addr(input int c);
        cb_rd_addr = c[7:0];
        @(posedge clk);
        check_entry(c[7:0], ref_codebook(c), cb_rd_entry);
        #1;
    endtask

    task automatic run_table(input int n);
        int c;
        tbl_n = n;
        ref_header_bytes();
        rx_count = 0;
        load_and_start();
        @(posedge clk);
        while (!done) @(posedge clk);
        repeat (2) @(posedge clk);  // room for a stray byte after done
        #1;
        if (rx_count < exp_bytes.size()) begin
            $display("missing bytes, expected %0d but received %0d", exp_bytes.size(), rx_count);
            other_errs++;
        end
        // stale characters of the previous table must read as empty
        for (c = 0; c < huffman_pkg::max_chars; c++) begin
            if (used[c] || prev_used[c]) check_addr(c);
        end
        for (c = 0; c < 4; c++) begin
            check_addr($urandom % huffman_pkg::max_chars);
        end
    endtask

    task automatic reset_mid_walk();
        int i;
        bit early_done;
        new_table();
        make_random_table(12);
        tbl_n = 12;
        ref_header_bytes();
        rx_count = 0;
        load_and_start();
        repeat (40) @(posedge clk);
        #1;
        rst = 1'b1;
        exp_bytes.delete();  // anything after this point is unexpected
        rx_count   = 0;
        early_done = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (i = 0; i < 60; i++) begin
            @(posedge clk);
            if (done) early_done = 1'b1;
        end
        #1;
        if (early_done) begin
            $display("done went high after a reset without a completed run");
            other_errs++;
        end
    endtask

    initial begin
        int n;
        int t;
        seed = 32'hf908;
        void'($urandom(seed));
        clk         = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        num_records = '0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_rec    = '0;
        cb_rd_addr  = '0;
        cycles      = 0;
        rx_count    = 0;
        byte_errs   = 0;
        entry_errs  = 0;
        other_errs  = 0;
        for (n = 0; n < huffman_pkg::max_chars; n++) begin
            used[n]      = 1'b0;
            prev_used[n] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        new_table();
        put_rec(0, char_node(8'h41), char_node(8'h7e));  // single pair
        run_table(1);

        new_table();
        put_rec(0, char_node(8'h10), char_node(8'h20));
        put_rec(1, char_node(8'h30), sum_node(0));      // sum as least2
        put_rec(2, sum_node(1), char_node(8'h05));      // sum as least1
        run_table(3);

        for (t = 0; t < num_random; t++) begin
            n = 2 + $urandom % 15;
            new_table();
            make_random_table(n);
            run_table(n);
        end

        reset_mid_walk();
        new_table();
        make_random_table(16);
        run_table(16);

        $display("byte errors %0d, codebook errors %0d, other errors %0d",
                 byte_errs, entry_errs, other_errs);
        if (byte_errs + entry_errs + other_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- huffman_header_top.f
+incdir+.
huffman_pkg.sv
merge_table.sv
cb_synthesis.sv
header_synthesis.sv
bit_packer.sv
codebook_ram.sv
huffman_header_top.sv
tb_huffman_header.sv
